//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module pipe_tb -o pipe_sim
out=$(./obj_dir/pipe_sim) || true
echo "$out"
echo "$out" | grep -qx "test passed"

//--- source/alu_execute.sv
module alu_execute (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       stall,
	input  pipe_cfg_pkg::ex_t          ex,
	output logic [isa_pkg::DATA_W-1:0] ex_forw,
	output pipe_cfg_pkg::wb_t          wb
);
	import isa_pkg::*;

	// Shift amount from B's low bits
	logic [4:0] shamt;

	assign shamt = ex.operand_b[4:0];

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb begin
		case (ex.op)
			op_add:  ex_forw = ex.operand_a + ex.operand_b;
			op_sub:  ex_forw = ex.operand_a - ex.operand_b;
			op_and:  ex_forw = ex.operand_a & ex.operand_b;
			op_or:   ex_forw = ex.operand_a | ex.operand_b;
			op_xor:  ex_forw = ex.operand_a ^ ex.operand_b;
			// Logical shifts only
			op_shl:  ex_forw = ex.operand_a << shamt;
			op_shr:  ex_forw = ex.operand_a >> shamt;
			default: ex_forw = '0;
		endcase
	end

	// Execute to writeback register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else if (!stall) begin
			wb.valid <= ex.valid;
			wb.rd    <= ex.rd;
			wb.value <= ex_forw;
		end
	end

endmodule

//--- source/instr_decode.sv
module instr_decode (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       stall,
	input  logic                       q_valid,
	input  isa_pkg::instr_t            q_instr,
	output logic                       pop,
	output logic [isa_pkg::REG_AW-1:0] rd_addr_a,
	output logic [isa_pkg::REG_AW-1:0] rd_addr_b,
	input  logic [isa_pkg::DATA_W-1:0] rd_data_a,
	input  logic [isa_pkg::DATA_W-1:0] rd_data_b,
	input  logic [isa_pkg::REG_AW-1:0] ex_rd,
	input  logic                       ex_valid,
	input  logic [isa_pkg::REG_AW-1:0] wb_rd,
	input  logic                       wb_valid,
	output pipe_cfg_pkg::dec_t         dec
);
	import isa_pkg::*;
	import pipe_cfg_pkg::*;

	// ID stage instruction register
	logic   id_valid;
	instr_t id_instr;

	// Take the head entry whenever the pipe moves
	assign pop = q_valid && !stall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
		end else if (!stall) begin
			// Empty queue loads a bubble
			id_valid <= q_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_instr <= q_instr;
		end
	end

	// Register file read addresses
	assign rd_addr_a = id_instr.rs_a;
	assign rd_addr_b = id_instr.rs_b;

	//////////////////////////////
	// Decode and forwarding selects
	//////////////////////////////
	always_comb begin
		dec.valid = id_valid;
		dec.op    = id_instr.op;
		dec.rd    = id_instr.rd;
		dec.rf_a  = rd_data_a;
		dec.rf_b  = rd_data_b;
		// Sign-extended immediate
		dec.simm  = {{(DATA_W - IMM_W){id_instr.imm[IMM_W-1]}}, id_instr.imm};

		// Newest producer wins
		if (ex_valid && (ex_rd == id_instr.rs_a)) begin
			dec.sel_a = sel_ex_forw;
		end else if (wb_valid && (wb_rd == id_instr.rs_a)) begin
			dec.sel_a = sel_wb_forw;
		end else begin
			dec.sel_a = sel_rf;
		end

		// Immediate beats any forwarding on B
		if (id_instr.use_imm) begin
			dec.sel_b = sel_imm;
		end else if (ex_valid && (ex_rd == id_instr.rs_b)) begin
			dec.sel_b = sel_ex_forw;
		end else if (wb_valid && (wb_rd == id_instr.rs_b)) begin
			dec.sel_b = sel_wb_forw;
		end else begin
			dec.sel_b = sel_rf;
		end
	end

endmodule

//--- source/instr_queue.sv
module instr_queue (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            instr_valid,
	input  isa_pkg::instr_t instr,
	input  logic            pop,
	output logic            q_valid,
	output isa_pkg::instr_t q_instr,
	output logic            instr_credit
);
	import isa_pkg::*;
	import pipe_cfg_pkg::*;

	// Circular storage and its pointers
	instr_t              mem [INSTR_DEPTH];
	logic [INSTR_AW-1:0] head;
	logic [INSTR_AW-1:0] tail;
	logic [INSTR_AW:0]   count;
	logic                push_fire;
	logic                pop_fire;

	// A push into a full queue is dropped
	assign push_fire = instr_valid && (count != (INSTR_AW + 1)'(INSTR_DEPTH));
	assign pop_fire  = pop && q_valid;

	// Head entry offered to decode
	assign q_valid = (count != '0);
	assign q_instr = mem[head];

	always_ff @(posedge clk) begin
		if (push_fire) begin
			mem[tail] <= instr;
		end
	end

	//////////////////////////////
	// Pointers, fill level, credit return
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			instr_credit <= 1'b0;
		end else begin
			// Depth is a power of two so pointers wrap on their own
			if (push_fire) begin
				tail <= tail + INSTR_AW'(1);
			end
			if (pop_fire) begin
				head <= head + INSTR_AW'(1);
			end
			case ({push_fire, pop_fire})
				2'b10:   count <= count + (INSTR_AW + 1)'(1);
				2'b01:   count <= count - (INSTR_AW + 1)'(1);
				default: count <= count;
			endcase
			// One credit back per freed slot
			instr_credit <= pop_fire;
		end
	end

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

	//////////////////////////////
	// Datapath geometry
	//////////////////////////////

	// Operand and result width
	localparam int DATA_W = 32;
	// Register file size and address width
	localparam int REG_N  = 8;
	localparam int REG_AW = 3;
	// Immediate field width before sign extension
	localparam int IMM_W  = 12;

	// ALU operations
	// Code 3'd7 is left unused
	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_shl,
		op_shr
	} opcode_t;

	// Instruction word as sent over the input channel
	typedef struct packed {
		opcode_t           op;
		logic              use_imm;  // B operand is the immediate
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs_a;
		logic [REG_AW-1:0] rs_b;
		logic [IMM_W-1:0]  imm;
	} instr_t;

	// One record per retired instruction
	typedef struct packed {
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] value;
	} result_t;

endpackage

//--- source/operand_mux.sv
module operand_mux (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       stall,
	input  pipe_cfg_pkg::dec_t         dec,
	input  logic [isa_pkg::DATA_W-1:0] ex_forw,
	input  logic [isa_pkg::DATA_W-1:0] wb_forw,
	output pipe_cfg_pkg::ex_t          ex
);
	import isa_pkg::*;
	import pipe_cfg_pkg::*;

	logic [DATA_W-1:0] muxed_a;
	logic [DATA_W-1:0] muxed_b;
	// Operands captured when a stall begins
	logic [DATA_W-1:0] held_a;
	logic [DATA_W-1:0] held_b;
	logic              saved;

	//////////////////////////////
	// Forwarding muxes
	//////////////////////////////
	always_comb begin
		case (dec.sel_a)
			sel_ex_forw: muxed_a = ex_forw;
			sel_wb_forw: muxed_a = wb_forw;
			default:     muxed_a = dec.rf_a;
		endcase
	end

	always_comb begin
		case (dec.sel_b)
			sel_imm:     muxed_b = dec.simm;
			sel_ex_forw: muxed_b = ex_forw;
			sel_wb_forw: muxed_b = wb_forw;
			default:     muxed_b = dec.rf_b;
		endcase
	end

	// First stalled cycle freezes the operands
	always_ff @(posedge clk) begin
		if (stall && !saved) begin
			held_a <= muxed_a;
			held_b <= muxed_b;
		end
	end

	//////////////////////////////
	// Execute entry register
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex    <= '0;
			saved <= 1'b0;
		end else if (stall) begin
			saved <= 1'b1;
		end else begin
			ex.valid     <= dec.valid;
			ex.op        <= dec.op;
			ex.rd        <= dec.rd;
			// Held copy overrides anything seen during the stall
			ex.operand_a <= saved ? held_a : muxed_a;
			ex.operand_b <= saved ? held_b : muxed_b;
			saved        <= 1'b0;
		end
	end

endmodule

//--- source/pipe_cfg_pkg.sv
package pipe_cfg_pkg;
	import isa_pkg::*;

	// Input queue depth and the sender's starting credits
	localparam int INSTR_DEPTH = 4;
	localparam int INSTR_AW    = $clog2(INSTR_DEPTH);
	// Starting output credits at writeback
	localparam int RES_CREDITS = 2;
	localparam int RES_CW      = $clog2(RES_CREDITS + 1);

	// Operand source select
	typedef enum logic [1:0] {
		sel_rf      = 2'd0,
		sel_imm     = 2'd1,
		sel_ex_forw = 2'd2,
		sel_wb_forw = 2'd3
	} fwd_sel_t;

	// Decode results handed to the operand stage
	typedef struct packed {
		logic              valid;
		opcode_t           op;
		logic [REG_AW-1:0] rd;
		fwd_sel_t          sel_a;
		fwd_sel_t          sel_b;
		logic [DATA_W-1:0] rf_a;
		logic [DATA_W-1:0] rf_b;
		logic [DATA_W-1:0] simm;
	} dec_t;

	// Execute stage entry
	typedef struct packed {
		logic              valid;
		opcode_t           op;
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] operand_a;
		logic [DATA_W-1:0] operand_b;
	} ex_t;

	// Writeback stage entry
	typedef struct packed {
		logic              valid;
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] value;
	} wb_t;

endpackage

//--- source/pipe_top.sv
module pipe_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             instr_valid,
	input  isa_pkg::instr_t  instr,
	output logic             instr_credit,
	output logic             res_valid,
	output isa_pkg::result_t res,
	input  logic             res_credit
);
	import isa_pkg::*;
	import pipe_cfg_pkg::*;

	// Queue to decode
	logic              q_valid;
	instr_t            q_instr;
	logic              pop;
	// Register file read ports
	logic [REG_AW-1:0] rd_addr_a;
	logic [REG_AW-1:0] rd_addr_b;
	logic [DATA_W-1:0] rd_data_a;
	logic [DATA_W-1:0] rd_data_b;
	// Stage entries
	dec_t              dec;
	ex_t               ex;
	wb_t               wb;
	logic [DATA_W-1:0] ex_forw;
	// Global hold from writeback
	logic              stall;

	instr_queue u_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.pop          (pop),
		.q_valid      (q_valid),
		.q_instr      (q_instr),
		.instr_credit (instr_credit)
	);

	instr_decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (stall),
		.q_valid   (q_valid),
		.q_instr   (q_instr),
		.pop       (pop),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.ex_rd     (ex.rd),
		.ex_valid  (ex.valid),
		.wb_rd     (wb.rd),
		.wb_valid  (wb.valid),
		.dec       (dec)
	);

	operand_mux u_opmux (
		.clk     (clk),
		.rst_n   (rst_n),
		.stall   (stall),
		.dec     (dec),
		.ex_forw (ex_forw),
		.wb_forw (wb.value),
		.ex      (ex)
	);

	alu_execute u_alu (
		.clk     (clk),
		.rst_n   (rst_n),
		.stall   (stall),
		.ex      (ex),
		.ex_forw (ex_forw),
		.wb      (wb)
	);

	result_writeback u_wb (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb         (wb),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.stall      (stall),
		.res_valid  (res_valid),
		.res        (res),
		.res_credit (res_credit)
	);

endmodule

//--- source/result_writeback.sv
module result_writeback (
	input  logic                       clk,
	input  logic                       rst_n,
	input  pipe_cfg_pkg::wb_t          wb,
	input  logic [isa_pkg::REG_AW-1:0] rd_addr_a,
	input  logic [isa_pkg::REG_AW-1:0] rd_addr_b,
	output logic [isa_pkg::DATA_W-1:0] rd_data_a,
	output logic [isa_pkg::DATA_W-1:0] rd_data_b,
	output logic                       stall,
	output logic                       res_valid,
	output isa_pkg::result_t           res,
	input  logic                       res_credit
);
	import isa_pkg::*;
	import pipe_cfg_pkg::*;

	logic [DATA_W-1:0] rf [REG_N];
	// Credits held toward the result consumer
	logic [RES_CW-1:0] credits;
	logic              send;

	// Retire only with a credit in hand
	assign send  = wb.valid && (credits != '0);
	assign stall = wb.valid && (credits == '0);

	// Asynchronous read ports
	assign rd_data_a = rf[rd_addr_a];
	assign rd_data_b = rf[rd_addr_b];

	//////////////////////////////
	// Register file
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_N; i++) begin
				rf[i] <= '0;
			end
		end else if (send) begin
			rf[wb.rd] <= wb.value;
		end
	end

	//////////////////////////////
	// Output credits and result valid
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits   <= RES_CW'(RES_CREDITS);
			res_valid <= 1'b0;
		end else begin
			// Return and spend in one cycle cancel out
			case ({res_credit, send})
				2'b10:   credits <= credits + RES_CW'(1);
				2'b01:   credits <= credits - RES_CW'(1);
				default: credits <= credits;
			endcase
			res_valid <= send;
		end
	end

	// Result record
	always_ff @(posedge clk) begin
		if (send) begin
			res.rd    <= wb.rd;
			res.value <= wb.value;
		end
	end

endmodule

//--- testbench/pipe_assert.sv
module pipe_assert (
	input logic              clk,
	input logic              rst_n,
	input logic              instr_valid,
	input logic              pop,
	input logic              q_valid,
	input logic              instr_credit,
	input logic              res_valid,
	input logic              res_credit,
	input logic              stall,
	input pipe_cfg_pkg::ex_t ex,
	input pipe_cfg_pkg::wb_t wb
);
	timeunit 1ns;
	timeprecision 1ps;
	import pipe_cfg_pkg::*;

	// Queue fill level seen from the channel
	int occupancy;
	// Output credits counted at the consumer side
	int out_credits;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			occupancy   <= 0;
			out_credits <= RES_CREDITS;
		end else begin
			occupancy   <= occupancy + int'(instr_valid) - int'(pop && q_valid);
			out_credits <= out_credits + int'(res_credit) - int'(res_valid);
		end
	end

	//////////////////////////////
	// Channel rules
	//////////////////////////////
	no_full_push: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid |-> occupancy < INSTR_DEPTH)
		else $error("push into a full instruction queue");

	// Credit returned in the send cycle is not yet usable
	send_with_credit: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> out_credits > int'($past(res_credit)))
		else $error("result sent without an output credit");

	// Stage entries frozen while writeback stalls
	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(ex) && $stable(wb))
		else $error("stage entry changed during stall");

	known_outputs: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({res_valid, instr_credit}))
		else $error("unknown value on res_valid or instr_credit");

endmodule

bind pipe_top pipe_assert u_assert (
	.clk          (clk),
	.rst_n        (rst_n),
	.instr_valid  (instr_valid),
	.pop          (pop),
	.q_valid      (q_valid),
	.instr_credit (instr_credit),
	.res_valid    (res_valid),
	.res_credit   (res_credit),
	.stall        (stall),
	.ex           (ex),
	.wb           (wb)
);

//--- testbench/pipe_tb.sv
module pipe_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import isa_pkg::*;
	import pipe_cfg_pkg::*;

	// Roughly four times the summed test lengths
	localparam int TIMEOUT_CYCLES = 4000;
	// Idle window of twice the four-cycle latency
	localparam int IDLE_CYCLES = 8;

	logic             clk;
	logic             rst_n;
	logic             instr_valid;
	instr_t           instr;
	logic             instr_credit;
	logic             res_valid;
	result_t          res;
	logic             res_credit;

	// Architectural register file of the reference model
	logic [DATA_W-1:0] ref_rf [REG_N];
	result_t           exp_q [$];
	result_t           exp_res;
	int                seed;
	int                credit_mode = 0;
	int                cycles = 0;
	// Channel bookkeeping, one writer each
	int                sent = 0;
	int                credit_pulses = 0;
	int                results_seen = 0;
	int                credits_given = 0;
	int                cmp_errors = 0;
	int                cmp_passes = 0;
	int                main_errors = 0;
	int                main_passes = 0;

	pipe_top uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.instr_credit (instr_credit),
		.res_valid    (res_valid),
		.res          (res),
		.res_credit   (res_credit)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic logic [DATA_W-1:0] ref_alu(input instr_t i);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		a = ref_rf[i.rs_a];
		// Immediate is sign-extended to full width
		b = i.use_imm ? DATA_W'($signed(i.imm)) : ref_rf[i.rs_b];
		case (i.op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_shl:  return a << b[4:0];
			op_shr:  return a >> b[4:0];
			default: return '0;
		endcase
	endfunction

	function automatic instr_t build_instr(input opcode_t op, input logic use_imm,
			input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rs_a,
			input logic [REG_AW-1:0] rs_b, input logic [IMM_W-1:0] imm);
		instr_t i;
		i.op      = op;
		i.use_imm = use_imm;
		i.rd      = rd;
		i.rs_a    = rs_a;
		i.rs_b    = rs_b;
		i.imm     = imm;
		return i;
	endfunction

	function automatic instr_t rand_instr();
		instr_t i;
		i    = 25'($random(seed));
		// Code 7 is not a valid opcode
		i.op = opcode_t'(3'($unsigned($random(seed)) % 7));
		return i;
	endfunction

	// Wait for an input credit, push one instruction, log its expected result
	task automatic send_instr(input instr_t i);
		result_t e;
		while (INSTR_DEPTH + credit_pulses - sent == 0) begin
			@(posedge clk);
			#2;
		end
		instr_valid = 1'b1;
		instr       = i;
		sent++;
		e.rd        = i.rd;
		e.value     = ref_alu(i);
		ref_rf[i.rd] = e.value;
		exp_q.push_back(e);
		@(posedge clk);
		#2;
		instr_valid = 1'b0;
	endtask

	task automatic drain_and_report(input string name, input int err_mark);
		while (results_seen < sent) begin
			@(posedge clk);
			#2;
		end
		$display("%s done, %0d errors", name, cmp_errors + main_errors - err_mark);
	endtask

	//////////////////////////////
	// Result compare on the falling edge
	//////////////////////////////
	always @(negedge clk) begin
		if (instr_credit) begin
			credit_pulses++;
		end
		if (res_valid) begin
			results_seen++;
			if (exp_q.size() == 0) begin
				$display("result arrived with no instruction outstanding");
				cmp_errors++;
			end else begin
				exp_res = exp_q.pop_front();
				assert (res === exp_res) cmp_passes++;
				else begin
					$display("mismatch res: got %h expected %h", res, exp_res);
					cmp_errors++;
				end
			end
			// Never more unanswered results than output credits
			assert (results_seen - credits_given <= RES_CREDITS)
			else begin
				$display("more results arrived than output credits allow");
				cmp_errors++;
			end
		end
	end

	// Consumer, mode 1 withholds credits for 30 of every 40 cycles
	initial begin
		res_credit = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			if (credit_mode == 1 && (cycles % 40) < 30) begin
				res_credit = 1'b0;
			end else if (results_seen > credits_given) begin
				res_credit = 1'b1;
				credits_given++;
			end else begin
				res_credit = 1'b0;
			end
		end
	end

	// Timeout
	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timed out after %0d cycles with results still missing", cycles);
		$display("test failed");
		$finish;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		int err_mark;
		seed        = 32'hab2b;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		for (int r = 0; r < REG_N; r++) begin
			ref_rf[r] = '0;
		end
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;

		// 1: load known values, then every opcode against the immediate
		err_mark = cmp_errors + main_errors;
		for (int r = 1; r < REG_N; r++) begin
			send_instr(build_instr(op_add, 1'b1, 3'(r), 3'd0, 3'd0, {3'(r), 9'h0a5}));
		end
		for (int k = 0; k < 7; k++) begin
			send_instr(build_instr(opcode_t'(3'(k)), 1'b1, 3'(k % 4 + 1), 3'(k % 3 + 5),
				3'd0, 12'h813));
		end
		drain_and_report("test 1 register-immediate ops", err_mark);

		// 2: consumers at distance 1 to 3 on operand A and operand B
		err_mark = cmp_errors + main_errors;
		for (int d = 1; d <= 3; d++) begin
			for (int s = 0; s < 2; s++) begin
				send_instr(build_instr(op_add, 1'b1, 3'd1, 3'd1, 3'd0, 12'(d * 100 + s)));
				for (int f = 1; f < d; f++) begin
					send_instr(build_instr(op_xor, 1'b1, 3'(4 + f), 3'(4 + f), 3'd0, 12'h3c3));
				end
				if (s == 0) begin
					send_instr(build_instr(op_sub, 1'b0, 3'd2, 3'd1, 3'd3, 12'h000));
				end else begin
					send_instr(build_instr(op_or, 1'b0, 3'd2, 3'd3, 3'd1, 12'h000));
				end
			end
		end
		// Both operands from the same producer
		send_instr(build_instr(op_add, 1'b0, 3'd1, 3'd1, 3'd1, 12'h000));
		send_instr(build_instr(op_shr, 1'b0, 3'd6, 3'd1, 3'd1, 12'h000));
		drain_and_report("test 2 forwarding distances", err_mark);

		// 3: random stream, credits back at once
		err_mark = cmp_errors + main_errors;
		repeat (300) send_instr(rand_instr());
		drain_and_report("test 3 random stream", err_mark);

		// 4: random stream under output back-pressure
		err_mark    = cmp_errors + main_errors;
		credit_mode = 1;
		repeat (60) send_instr(rand_instr());
		drain_and_report("test 4 back-pressure", err_mark);
		credit_mode = 0;

		// 5: credit and result accounting over the whole run
		err_mark = cmp_errors + main_errors;
		// Pipe is idle here, so any further result is a duplicate
		repeat (IDLE_CYCLES) @(posedge clk);
		#2;
		assert (credit_pulses == sent) main_passes++;
		else begin
			$display("mismatch instr_credit pulses: got %h expected %h", credit_pulses, sent);
			main_errors++;
		end
		assert (results_seen == sent) main_passes++;
		else begin
			$display("mismatch res_valid count: got %h expected %h", results_seen, sent);
			main_errors++;
		end
		$display("test 5 credit accounting done, %0d errors", cmp_errors + main_errors - err_mark);

		$display("checks ok: %0d, errors: %0d", cmp_passes + main_passes,
			cmp_errors + main_errors);
		if (cmp_errors + main_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
source/isa_pkg.sv
source/pipe_cfg_pkg.sv
source/instr_queue.sv
source/instr_decode.sv
source/operand_mux.sv
source/alu_execute.sv
source/result_writeback.sv
source/pipe_top.sv
testbench/pipe_assert.sv
testbench/pipe_tb.sv
